//--- design/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Word addresses on the register bus
    localparam reg_addr_t REG_CONTROL = 4'd0;
    localparam reg_addr_t REG_STATUS  = 4'd1;
    localparam reg_addr_t REG_REF_LEN = 4'd2;
    localparam reg_addr_t REG_VERSION = 4'd3;
    localparam reg_addr_t REG_KEY     = 4'd4;
    localparam reg_addr_t REG_NQUERY  = 4'd5;

    // Major 31..28, minor 27..20, revision 19..16
    localparam reg_data_t VERSION_WORD = {4'd1, 8'd0, 4'd0, 16'h0000};
    localparam reg_data_t KEY_WORD     = 32'h0ca7_cafe;

    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // CONTROL bits 2..0
    typedef struct packed {
        logic mode;
        logic run;
        logic clear;
    } ctrl_t;

    // STATUS bits 8..0
    typedef struct packed {
        logic [2:0] core_state;
        logic       out_full;
        logic       out_empty;
        logic       in_full;
        logic       in_empty;
        logic       load_done;
        logic       busy;
    } status_t;

endpackage

`default_nettype wire

//--- design/sample_pkg.sv
`default_nettype none

package sample_pkg;

    // Raw signal sample from the input stream
    typedef logic signed [15:0] sample_t;

    // Accumulated distance for one query
    typedef logic [31:0] dist_t;

    // Reference index, wide enough to hold a full count of 64
    typedef logic [6:0] ref_idx_t;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        LOAD  = 3'd1,
        QUERY = 3'd2,
        EMIT  = 3'd3
    } core_state_t;

endpackage

`default_nettype wire

//--- design/sample_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sample_fifo #(
    parameter int WIDTH      = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic             S_AXI_clk,
    input  wire logic             w_axi_rst,
    input  wire logic             i_flush,

    input  wire logic             i_push,
    input  wire logic [WIDTH-1:0] i_wdata,
    output logic                  o_full,

    input  wire logic             i_pop,
    output logic      [WIDTH-1:0] o_rdata,
    output logic                  o_empty
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    assign o_full  = (count == CW'(FIFO_DEPTH));
    assign o_empty = (count == '0);
    assign o_rdata = mem[rd_ptr];

    // Overflow and underflow requests are dropped
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge S_AXI_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/csr_block.sv
`timescale 1ns/1ns
`default_nettype none

module csr_block
    import csr_pkg::*;
    import sample_pkg::*;
#(
    parameter int REF_DEPTH = 64
) (
    input  wire logic        S_AXI_clk,
    input  wire logic        w_axi_rst,

    input  wire reg_req_t    i_reg_req,
    output logic             o_reg_rvalid,
    output reg_data_t        o_reg_rdata,
    output logic             o_reg_err,

    output ctrl_t            o_ctrl,
    output ref_idx_t         o_ref_len,

    input  wire logic        i_busy,
    input  wire logic        i_load_done,
    input  wire core_state_t i_core_state,
    input  wire reg_data_t   i_nquery,

    input  wire logic        i_in_empty,
    input  wire logic        i_in_full,
    input  wire logic        i_out_empty,
    input  wire logic        i_out_full
);

    ctrl_t     ctrl;
    ref_idx_t  ref_len;
    status_t   status;
    logic      addr_ok;
    ref_idx_t  ref_len_wr;
    reg_data_t rd_mux;

    assign o_ctrl    = ctrl;
    assign o_ref_len = ref_len;

    always_comb begin
        status.busy       = i_busy;
        status.load_done  = i_load_done;
        status.in_empty   = i_in_empty;
        status.in_full    = i_in_full;
        status.out_empty  = i_out_empty;
        status.out_full   = i_out_full;
        status.core_state = i_core_state;
    end

    assign addr_ok = (i_reg_req.addr <= REG_NQUERY);

    // REF_LEN is kept within 1..REF_DEPTH
    always_comb begin
        if (i_reg_req.wdata > reg_data_t'(REF_DEPTH)) begin
            ref_len_wr = ref_idx_t'(REF_DEPTH);
        end else if (i_reg_req.wdata == '0) begin
            ref_len_wr = ref_idx_t'(1);
        end else begin
            ref_len_wr = ref_idx_t'(i_reg_req.wdata);
        end
    end

    always_comb begin
        case (i_reg_req.addr)
            REG_CONTROL: rd_mux = reg_data_t'(ctrl);
            REG_STATUS:  rd_mux = reg_data_t'(status);
            REG_REF_LEN: rd_mux = reg_data_t'(ref_len);
            REG_VERSION: rd_mux = VERSION_WORD;
            REG_KEY:     rd_mux = KEY_WORD;
            REG_NQUERY:  rd_mux = i_nquery;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            ctrl         <= '0;
            ref_len      <= '0;
            o_reg_rvalid <= 1'b0;
            o_reg_err    <= 1'b0;
        end else begin
            o_reg_rvalid <= i_reg_req.rd;
            o_reg_err    <= (i_reg_req.wr || i_reg_req.rd) && !addr_ok;
            // Read-only addresses fall through without effect
            if (i_reg_req.wr) begin
                if (i_reg_req.addr == REG_CONTROL) begin
                    ctrl <= ctrl_t'(i_reg_req.wdata[2:0]);
                end
                if (i_reg_req.addr == REG_REF_LEN) begin
                    ref_len <= ref_len_wr;
                end
            end
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (i_reg_req.rd) begin
            o_reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- design/match_core.sv
`timescale 1ns/1ns
`default_nettype none

module match_core
    import csr_pkg::*;
    import sample_pkg::*;
#(
    parameter int REF_DEPTH = 64
) (
    input  wire logic     S_AXI_clk,
    input  wire logic     w_axi_rst,

    input  wire ctrl_t    i_ctrl,
    input  wire ref_idx_t i_ref_len,

    input  wire logic     i_in_empty,
    input  wire sample_t  i_in_data,
    output logic          o_in_pop,

    input  wire logic     i_out_full,
    output logic          o_out_push,
    output dist_t         o_out_data,

    output logic          o_busy,
    output logic          o_load_done,
    output core_state_t   o_state,
    output reg_data_t     o_nquery
);

    localparam int AW = (REF_DEPTH > 1) ? $clog2(REF_DEPTH) : 1;

    sample_t           ref_mem [REF_DEPTH];
    core_state_t       state;
    ref_idx_t          idx;
    ref_idx_t          idx_next;
    logic              last;
    dist_t             acc;
    logic              load_done;
    reg_data_t         nquery;
    sample_t           ref_smp;
    logic signed [16:0] diff;
    dist_t             abs_diff;

    assign ref_smp  = ref_mem[idx[AW-1:0]];
    assign idx_next = idx + 1'b1;
    assign last     = (idx_next >= i_ref_len);

    // 17 bits hold any difference of two samples
    always_comb begin
        diff = 17'(i_in_data) - 17'(ref_smp);
        if (diff < 0) begin
            abs_diff = dist_t'(-diff);
        end else begin
            abs_diff = dist_t'(diff);
        end
    end

    assign o_in_pop    = ((state == LOAD) || (state == QUERY)) && !i_in_empty && !i_ctrl.clear;
    assign o_out_push  = (state == EMIT) && !i_out_full;
    assign o_out_data  = acc;
    assign o_busy      = (state != IDLE);
    assign o_load_done = load_done;
    assign o_state     = state;
    assign o_nquery    = nquery;

    // Reference write port
    always_ff @(posedge S_AXI_clk) begin
        if (state == LOAD && o_in_pop) begin
            ref_mem[idx[AW-1:0]] <= i_in_data;
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_ctrl.clear) begin
            state     <= IDLE;
            idx       <= '0;
            load_done <= 1'b0;
            nquery    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    idx <= '0;
                    // A loaded reference stays until the next clear
                    if (i_ctrl.run) begin
                        if (!i_ctrl.mode && !load_done) begin
                            state <= LOAD;
                        end else if (i_ctrl.mode && load_done) begin
                            state <= QUERY;
                        end
                    end
                end
                LOAD: begin
                    if (o_in_pop) begin
                        idx <= idx_next;
                        if (last) begin
                            load_done <= 1'b1;
                            state     <= IDLE;
                        end
                    end
                end
                QUERY: begin
                    if (o_in_pop) begin
                        idx <= idx_next;
                        if (last) begin
                            state <= EMIT;
                        end
                    end
                end
                EMIT: begin
                    // Hold here while the output FIFO is full
                    if (o_out_push) begin
                        nquery <= nquery + 1'b1;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Sum restarts with the first sample of each query
    always_ff @(posedge S_AXI_clk) begin
        if (state == QUERY && o_in_pop) begin
            if (idx == '0) begin
                acc <= abs_diff;
            end else begin
                acc <= acc + abs_diff;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/match_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

module match_accel_top
    import csr_pkg::*;
    import sample_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int REF_DEPTH  = 64
) (
    input  wire logic     S_AXI_clk,
    input  wire logic     w_axi_rst,

    // Sample stream in
    input  wire logic     i_in_valid,
    input  wire sample_t  i_in_data,
    output logic          o_in_ready,

    // Distance stream out
    output logic          o_out_valid,
    output dist_t         o_out_data,
    input  wire logic     i_out_ready,

    // Register bus
    input  wire reg_req_t i_reg_req,
    output logic          o_reg_rvalid,
    output reg_data_t     o_reg_rdata,
    output logic          o_reg_err
);

    ctrl_t       ctrl;
    ref_idx_t    ref_len;
    logic        in_empty;
    logic        in_full;
    logic        in_pop;
    sample_t     in_head;
    logic        out_empty;
    logic        out_full;
    logic        out_push;
    dist_t       out_wdata;
    logic        core_busy;
    logic        core_load_done;
    core_state_t core_state;
    reg_data_t   core_nquery;

    assign o_in_ready  = !in_full;
    assign o_out_valid = !out_empty;

    sample_fifo #(
        .WIDTH      ($bits(sample_t)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_in_fifo (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_flush   (ctrl.clear),
        .i_push    (i_in_valid && o_in_ready),
        .i_wdata   (i_in_data),
        .o_full    (in_full),
        .i_pop     (in_pop),
        .o_rdata   (in_head),
        .o_empty   (in_empty)
    );

    match_core #(
        .REF_DEPTH (REF_DEPTH)
    ) u_match_core (
        .S_AXI_clk   (S_AXI_clk),
        .w_axi_rst   (w_axi_rst),
        .i_ctrl      (ctrl),
        .i_ref_len   (ref_len),
        .i_in_empty  (in_empty),
        .i_in_data   (in_head),
        .o_in_pop    (in_pop),
        .i_out_full  (out_full),
        .o_out_push  (out_push),
        .o_out_data  (out_wdata),
        .o_busy      (core_busy),
        .o_load_done (core_load_done),
        .o_state     (core_state),
        .o_nquery    (core_nquery)
    );

    sample_fifo #(
        .WIDTH      ($bits(dist_t)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_flush   (1'b0),
        .i_push    (out_push),
        .i_wdata   (out_wdata),
        .o_full    (out_full),
        .i_pop     (o_out_valid && i_out_ready),
        .o_rdata   (o_out_data),
        .o_empty   (out_empty)
    );

    csr_block #(
        .REF_DEPTH (REF_DEPTH)
    ) u_csr_block (
        .S_AXI_clk    (S_AXI_clk),
        .w_axi_rst    (w_axi_rst),
        .i_reg_req    (i_reg_req),
        .o_reg_rvalid (o_reg_rvalid),
        .o_reg_rdata  (o_reg_rdata),
        .o_reg_err    (o_reg_err),
        .o_ctrl       (ctrl),
        .o_ref_len    (ref_len),
        .i_busy       (core_busy),
        .i_load_done  (core_load_done),
        .i_core_state (core_state),
        .i_nquery     (core_nquery),
        .i_in_empty   (in_empty),
        .i_in_full    (in_full),
        .i_out_empty  (out_empty),
        .i_out_full   (out_full)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release just after the last reset edge
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/match_accel_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module match_accel_assertions
    import csr_pkg::*;
    import sample_pkg::*;
(
    input wire logic     S_AXI_clk,
    input wire logic     w_axi_rst,
    input wire logic     o_out_valid,
    input wire dist_t    o_out_data,
    input wire logic     i_out_ready,
    input wire reg_req_t i_reg_req,
    input wire logic     o_reg_rvalid,
    input wire logic     o_reg_err
);

    int fail_count = 0;

    // Stalled output keeps valid and data
    out_hold: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data))
    else begin
        $error("o_out_valid or o_out_data changed while stalled");
        fail_count++;
    end

    rd_response: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        i_reg_req.rd |=> o_reg_rvalid)
    else begin
        $error("o_reg_rvalid missing one cycle after read request");
        fail_count++;
    end

    rd_no_stray: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        !i_reg_req.rd |=> !o_reg_rvalid)
    else begin
        $error("o_reg_rvalid without a read request");
        fail_count++;
    end

    // First reset edge is skipped, outputs are not yet defined there
    rst_quiet: assert property (@(posedge S_AXI_clk)
        w_axi_rst && $past(w_axi_rst) |-> !o_reg_rvalid && !o_reg_err)
    else begin
        $error("register response active during reset");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- dv/match_accel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module match_accel_tb
    import csr_pkg::*;
    import sample_pkg::*;
();

    localparam int FIFO_DEPTH  = 4;
    localparam int REF_DEPTH   = 64;
    localparam int REF_LEN     = 16;
    localparam int NQ          = 8;
    localparam int CYCLE_LIMIT = 20 * (NQ * REF_LEN + 200);
    localparam reg_data_t EXP_VERSION = 32'h1000_0000;
    localparam reg_data_t EXP_KEY     = 32'h0ca7_cafe;

    logic      S_AXI_clk;
    logic      w_axi_rst;
    logic      in_valid;
    sample_t   in_data;
    logic      in_ready;
    logic      out_valid;
    dist_t     out_data;
    logic      out_ready;
    reg_req_t  reg_req;
    logic      reg_rvalid;
    reg_data_t reg_rdata;
    logic      reg_err;

    sample_t ref_samples [REF_LEN];
    sample_t query_samples [NQ][REF_LEN];
    logic    ready_pattern [256];
    logic [7:0] ready_idx;
    dist_t   exp_q [$];
    int      cycle_count = 0;
    int      word_errors = 0;
    int      dist_errors = 0;
    int      flag_errors = 0;
    int      other_errors = 0;

    tb_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .o_clk (S_AXI_clk),
        .o_rst (w_axi_rst)
    );

    match_accel_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .REF_DEPTH  (REF_DEPTH)
    ) i_match_accel_top (
        .S_AXI_clk    (S_AXI_clk),
        .w_axi_rst    (w_axi_rst),
        .i_in_valid   (in_valid),
        .i_in_data    (in_data),
        .o_in_ready   (in_ready),
        .o_out_valid  (out_valid),
        .o_out_data   (out_data),
        .i_out_ready  (out_ready),
        .i_reg_req    (reg_req),
        .o_reg_rvalid (reg_rvalid),
        .o_reg_rdata  (reg_rdata),
        .o_reg_err    (reg_err)
    );

    bind match_accel_top match_accel_assertions u_assertions (
        .S_AXI_clk    (S_AXI_clk),
        .w_axi_rst    (w_axi_rst),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data),
        .i_out_ready  (i_out_ready),
        .i_reg_req    (i_reg_req),
        .o_reg_rvalid (o_reg_rvalid),
        .o_reg_err    (o_reg_err)
    );

    // Sum of absolute differences, sample by sample
    function automatic dist_t expected_distance(input int qn);
        int sum;
        int d;
        sum = 0;
        for (int i = 0; i < REF_LEN; i++) begin
            d = int'(query_samples[qn][i]) - int'(ref_samples[i]);
            if (d < 0) begin
                d = -d;
            end
            sum += d;
        end
        return dist_t'(sum);
    endfunction

    task automatic check_word(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            word_errors++;
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_dist(input string name, input dist_t got, input dist_t exp);
        if (got !== exp) begin
            dist_errors++;
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // All bus tasks start and end 1 ns after a rising edge
    task automatic reg_write(input reg_addr_t a, input reg_data_t d);
        reg_req = '{wr: 1'b1, rd: 1'b0, addr: a, wdata: d};
        @(posedge S_AXI_clk);
        #1;
        reg_req = '0;
    endtask

    task automatic reg_read(input reg_addr_t a, output reg_data_t d, output logic err);
        reg_req = '{wr: 1'b0, rd: 1'b1, addr: a, wdata: '0};
        @(posedge S_AXI_clk);
        #1;
        reg_req = '0;
        check_flag("o_reg_rvalid", reg_rvalid, 1'b1);
        d   = reg_rdata;
        err = reg_err;
    endtask

    task automatic read_expect(input reg_addr_t a, input reg_data_t exp, input string name);
        reg_data_t got;
        logic      err;
        reg_read(a, got, err);
        check_word({"o_reg_rdata (", name, ")"}, got, exp);
        check_flag({"o_reg_err (", name, ")"}, err, 1'b0);
    endtask

    // Holds valid high, caller drops it after a burst
    task automatic send_sample(input sample_t s);
        in_valid = 1'b1;
        in_data  = s;
        do begin
            @(negedge S_AXI_clk);
        end while (!in_ready);
        @(posedge S_AXI_clk);
        #1;
    endtask

    always @(posedge S_AXI_clk) begin
        #1;
        out_ready = ready_pattern[ready_idx];
        ready_idx = ready_idx + 8'd1;
    end

    // Output transfer happens at the next rising edge
    always @(negedge S_AXI_clk) begin
        if (!w_axi_rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Output distance %0d arrived with no query pending", out_data);
            end else begin
                check_dist("o_out_data", out_data, exp_q.pop_front());
            end
        end
    end

    always @(posedge S_AXI_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reg_data_t word;
        logic      err;
        status_t   st;
        int        polls;
        int        total;

        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        reg_req   = '0;
        ready_idx = '0;

        void'($urandom(3));
        for (int i = 0; i < 256; i++) begin
            ready_pattern[i] = ($urandom & 1) != 0;
        end
        for (int i = 0; i < REF_LEN; i++) begin
            ref_samples[i] = sample_t'($urandom);
        end
        for (int q = 0; q < NQ; q++) begin
            for (int i = 0; i < REF_LEN; i++) begin
                query_samples[q][i] = sample_t'($urandom);
            end
        end

        do begin
            @(posedge S_AXI_clk);
        end while (w_axi_rst);
        #1;

        // Reset values
        check_flag("o_in_ready", in_ready, 1'b1);
        check_flag("o_out_valid", out_valid, 1'b0);
        read_expect(REG_VERSION, EXP_VERSION, "VERSION");
        read_expect(REG_KEY, EXP_KEY, "KEY");
        read_expect(REG_CONTROL, '0, "CONTROL");
        read_expect(REG_NQUERY, '0, "NQUERY");
        reg_read(REG_STATUS, word, err);
        st = status_t'(word[8:0]);
        check_flag("STATUS.in_empty", st.in_empty, 1'b1);
        check_flag("STATUS.out_empty", st.out_empty, 1'b1);
        check_flag("STATUS.load_done", st.load_done, 1'b0);
        check_flag("STATUS.busy", st.busy, 1'b0);

        // Bad address, read-only write, REF_LEN clamp
        reg_read(reg_addr_t'(9), word, err);
        check_flag("o_reg_err (addr 9)", err, 1'b1);
        check_word("o_reg_rdata (addr 9)", word, '0);
        reg_write(REG_KEY, 32'h1234_5678);
        read_expect(REG_KEY, EXP_KEY, "KEY after write");
        reg_write(REG_REF_LEN, 32'd100);
        read_expect(REG_REF_LEN, reg_data_t'(REF_DEPTH), "REF_LEN clamped");

        // Load the reference
        reg_write(REG_REF_LEN, reg_data_t'(REF_LEN));
        read_expect(REG_REF_LEN, reg_data_t'(REF_LEN), "REF_LEN");
        reg_write(REG_CONTROL, 32'h2);
        for (int i = 0; i < REF_LEN; i++) begin
            send_sample(ref_samples[i]);
        end
        in_valid = 1'b0;
        polls = 0;
        do begin
            reg_read(REG_STATUS, word, err);
            st = status_t'(word[8:0]);
            polls++;
        end while (!(st.load_done && !st.busy) && polls < 200);
        if (!(st.load_done && !st.busy)) begin
            other_errors++;
            $display("Reference load did not complete after %0d status reads", polls);
        end

        // Queries, the checker consumes the expected queue
        reg_write(REG_CONTROL, 32'h6);
        for (int q = 0; q < NQ; q++) begin
            exp_q.push_back(expected_distance(q));
            for (int i = 0; i < REF_LEN; i++) begin
                send_sample(query_samples[q][i]);
            end
        end
        in_valid = 1'b0;
        // Mode 0 with a loaded reference keeps the core in IDLE after the last query
        reg_write(REG_CONTROL, 32'h2);
        while (exp_q.size() != 0) begin
            @(posedge S_AXI_clk);
            #1;
        end
        read_expect(REG_NQUERY, reg_data_t'(NQ), "NQUERY");

        // Samples wait in the input FIFO while the core is parked
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            send_sample(sample_t'(i + 1));
        end
        in_valid = 1'b0;
        check_flag("o_in_ready (input FIFO full)", in_ready, 1'b0);
        reg_read(REG_STATUS, word, err);
        st = status_t'(word[8:0]);
        check_flag("STATUS.in_full", st.in_full, 1'b1);
        check_flag("STATUS.busy", st.busy, 1'b0);

        // Clear drops the reference, the count and the queued samples
        reg_write(REG_CONTROL, 32'h1);
        // Core and input FIFO act on clear one edge after CONTROL changes
        @(posedge S_AXI_clk);
        #1;
        check_flag("o_in_ready after clear", in_ready, 1'b1);
        reg_read(REG_STATUS, word, err);
        st = status_t'(word[8:0]);
        check_flag("STATUS.load_done", st.load_done, 1'b0);
        check_flag("STATUS.in_empty", st.in_empty, 1'b1);
        read_expect(REG_NQUERY, '0, "NQUERY after clear");

        total = word_errors + dist_errors + flag_errors + other_errors
              + i_match_accel_top.u_assertions.fail_count;
        $display("Errors: register %0d, distance %0d, flag %0d, other %0d, assertion %0d",
                 word_errors, dist_errors, flag_errors, other_errors,
                 i_match_accel_top.u_assertions.fail_count);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/csr_pkg.sv
design/sample_pkg.sv
design/sample_fifo.sv
design/csr_block.sv
design/match_core.sv
design/match_accel_top.sv
dv/tb_clock_gen.sv
dv/match_accel_assertions.sv
dv/match_accel_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= match_accel_tb
RTL_TOP    ?= match_accel_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= +verilator+error+limit+100
PASS_TEXT  ?= TEST RESULT: PASS

RTL_SRCS := design/csr_pkg.sv design/sample_pkg.sv design/sample_fifo.sv \
            design/csr_block.sv design/match_core.sv design/match_accel_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
